// ==== Makefile ====
TOP  = tb_rv_core
SRCS = $(shell grep -v '^+' src.f) tests/rv_ref_model.svh

all: run

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== rtl/control_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_fsm import rv_isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  rv_instr_t imem_data,
    output rv_instr_t instr,
    exec_ctrl_if.ctrl ctl
);

    state_t  state;

    // Decoder outputs, sampled at the end of DECODE
    alu_op_t dec_alu_op;
    src_a_t  dec_src_a;
    src_b_t  dec_src_b;
    wb_sel_t dec_wb_sel;
    logic    dec_is_branch;
    logic    dec_is_jal;
    logic    dec_is_jalr;

    // ALU op from funct3, alt picks SUB or SRA
    function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_sel = ALU_SLL;
            F3_SLT:     alu_sel = ALU_SLT;
            F3_SLTU:    alu_sel = ALU_SLTU;
            F3_XOR:     alu_sel = ALU_XOR;
            F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_sel = ALU_OR;
            F3_AND:     alu_sel = ALU_AND;
            default:    alu_sel = ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= EXECUTE;
                EXECUTE: state <= WRITEBACK;
                default: state <= FETCH; // WRITEBACK wraps around
            endcase
        end
    end

    // Instruction register, imem_addr is pc during FETCH
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            instr <= imem_data;
        end
    end

    always_comb begin
        // Unknown opcodes fall out as pc + 4 with no write
        dec_alu_op    = ALU_ADD;
        dec_src_a     = SRC_A_PC;
        dec_src_b     = SRC_B_FOUR;
        dec_wb_sel    = WB_NONE;
        dec_is_branch = 1'b0;
        dec_is_jal    = 1'b0;
        dec_is_jalr   = 1'b0;
        case (instr.r_fmt.opcode)
            OP_REG: begin
                dec_src_a  = SRC_A_RS1;
                dec_src_b  = SRC_B_RS2;
                dec_wb_sel = WB_ALU;
                dec_alu_op = alu_sel(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
            end
            OP_IMM: begin
                dec_src_a  = SRC_A_RS1;
                dec_src_b  = SRC_B_IMM;
                dec_wb_sel = WB_ALU;
                // Bit 30 is a plain imm bit except on SRAI
                dec_alu_op = alu_sel(instr.i_fmt.funct3,
                                     (instr.i_fmt.funct3 == F3_SRL_SRA) && instr.r_fmt.funct7[5]);
            end
            OP_LUI: begin
                dec_src_a  = SRC_A_ZERO;
                dec_src_b  = SRC_B_IMM;
                dec_wb_sel = WB_ALU;
            end
            OP_AUIPC: begin
                dec_src_b  = SRC_B_IMM; // pc + imm
                dec_wb_sel = WB_ALU;
            end
            OP_JAL: begin
                dec_is_jal = 1'b1;
                dec_wb_sel = WB_PC4;
            end
            OP_JALR: begin
                dec_is_jalr = 1'b1;
                dec_src_a   = SRC_A_RS1; // ALU forms the target
                dec_src_b   = SRC_B_IMM;
                dec_wb_sel  = WB_PC4;
            end
            OP_BRANCH: begin
                dec_is_branch = 1'b1;
                dec_src_a     = SRC_A_RS1;
                dec_src_b     = SRC_B_RS2;
                dec_alu_op    = ALU_SUB;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl.alu_op        <= ALU_ADD;
            ctl.src_a         <= SRC_A_PC;
            ctl.src_b         <= SRC_B_FOUR;
            ctl.wb_sel        <= WB_NONE;
            ctl.is_branch     <= 1'b0;
            ctl.is_jal        <= 1'b0;
            ctl.is_jalr       <= 1'b0;
            ctl.branch_funct3 <= F3_BEQ;
        end else if (state == DECODE) begin
            ctl.alu_op        <= dec_alu_op;
            ctl.src_a         <= dec_src_a;
            ctl.src_b         <= dec_src_b;
            ctl.wb_sel        <= dec_wb_sel;
            ctl.is_branch     <= dec_is_branch;
            ctl.is_jal        <= dec_is_jal;
            ctl.is_jalr       <= dec_is_jalr;
            ctl.branch_funct3 <= instr.b_fmt.funct3;
        end
    end

    assign ctl.execute_en = (state == EXECUTE);
    assign ctl.retire_en  = (state == WRITEBACK);

    // Only one instruction retires per pass through the states
    a_retire_single: assert property (@(posedge clk) disable iff (reset)
        ctl.retire_en |=> !ctl.retire_en);

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Sequencer states, one clock each
    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        DECODE    = 2'd1,
        EXECUTE   = 2'd2,
        WRITEBACK = 2'd3
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_A_PC   = 2'd0,
        SRC_A_RS1  = 2'd1,
        SRC_A_ZERO = 2'd2 // LUI passes imm straight through
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'd0,
        SRC_B_IMM  = 2'd1,
        SRC_B_FOUR = 2'd2
    } src_b_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_PC4  = 2'd1, // Link value of JAL and JALR
        WB_NONE = 2'd2
    } wb_sel_t;

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam logic [31:0] INSTR_STEP = 32'd4;

endpackage

`default_nettype wire

// ==== rtl/exec_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decoded control, sequencer to execute unit
interface exec_ctrl_if import core_pkg::*; ();

    alu_op_t    alu_op;
    src_a_t     src_a;
    src_b_t     src_b;
    wb_sel_t    wb_sel;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic [2:0] branch_funct3;
    logic       execute_en;    // Pulse in EXECUTE
    logic       retire_en;     // Pulse in WRITEBACK

    modport ctrl (
        output alu_op, src_a, src_b, wb_sel,
        output is_branch, is_jal, is_jalr, branch_funct3,
        output execute_en, retire_en
    );

    modport exec (
        input alu_op, src_a, src_b, wb_sel,
        input is_branch, is_jal, is_jalr, branch_funct3,
        input execute_en, retire_en
    );

endinterface

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rv_isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    exec_ctrl_if.exec             ctl,
    input  rv_instr_t             instr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic [XLEN-1:0]       imm,
    output logic [XLEN-1:0]       imem_addr,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic                  rd_we,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       rd_data
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] next_pc_q;   // Held through WRITEBACK

    assign pc_plus4    = pc + INSTR_STEP;
    assign jump_target = pc + imm; // JAL and taken branches

    always_comb begin
        case (ctl.src_a)
            SRC_A_RS1:  op_a = rs1_data;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = pc;
        endcase
        case (ctl.src_b)
            SRC_B_RS2: op_b = rs2_data;
            SRC_B_IMM: op_b = imm;
            default:   op_b = INSTR_STEP;
        endcase
    end

    always_comb begin
        case (ctl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Compare directly on register data
    always_comb begin
        case (ctl.branch_funct3)
            F3_BEQ:  branch_taken = (rs1_data == rs2_data);
            F3_BNE:  branch_taken = (rs1_data != rs2_data);
            F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: branch_taken = (rs1_data < rs2_data);
            F3_BGEU: branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctl.is_jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0}; // rs1 + imm, lsb cleared
        end else if (ctl.is_jal || (ctl.is_branch && branch_taken)) begin
            next_pc = jump_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // Flags rise at the end of EXECUTE, drop at the end of WRITEBACK
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            rd_we        <= 1'b0;
        end else begin
            retire_valid <= ctl.execute_en;
            rd_we        <= ctl.execute_en && (ctl.wb_sel != WB_NONE) &&
                            (instr.r_fmt.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.execute_en) begin
            rd_data   <= (ctl.wb_sel == WB_PC4) ? pc_plus4 : alu_result;
            next_pc_q <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (ctl.retire_en) begin
            pc <= next_pc_q;
        end
    end

    assign rd_addr   = instr.r_fmt.rd;
    assign retire_pc = pc;        // pc moves only after WRITEBACK
    assign imem_addr = pc;

    // Targets from imm_gen and the JALR path keep word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
    input  rv_instr_t       instr,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (instr.r_fmt.opcode)
            OP_IMM, OP_JALR: begin
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            OP_STORE: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            end
            OP_BRANCH: begin // Halfword offset, bit 0 implied
                imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr.u_fmt.imm_31_12, 12'b0}; // Upper 20 bits
            end
            OP_JAL: begin
                imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            // R-type and the rest carry no immediate
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file import rv_isa_pkg::*; (
    input  logic                  clk,
    input  rv_instr_t             instr,
    input  logic                  rd_we,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [XLEN-1:0]       rd_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W]; // Entry 0 never written

    // Write at the end of WRITEBACK
    always_ff @(posedge clk) begin
        if (rd_we) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Async read straight off the instruction register
    assign rs1_data = (instr.r_fmt.rs1 == '0) ? '0 : regs[instr.r_fmt.rs1];
    assign rs2_data = (instr.r_fmt.rs2 == '0) ? '0 : regs[instr.r_fmt.rs2];

    // Execute unit must filter writes to x0
    a_no_x0_write: assert property (@(posedge clk) rd_we |-> (rd_addr != '0));

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       imem_data,
    output logic [XLEN-1:0]       imem_addr,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic                  rd_we,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       rd_data
);

    rv_instr_t       instr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;

    exec_ctrl_if u_ctl_if ();

    control_fsm u_control_fsm (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .instr     (instr),
        .ctl       (u_ctl_if.ctrl)
    );

    // Register read and immediate side by side
    register_file u_register_file (
        .clk      (clk),
        .instr    (instr),
        .rd_we    (rd_we),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    exec_unit u_exec_unit (
        .clk          (clk),
        .reset        (reset),
        .ctl          (u_ctl_if.exec),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rd_we        (rd_we),        // Also the register file write port
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011; // S immediate only, executes as no-op

    // ALU funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    // Scrambled immediate bits of the branch format
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One fetched word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_t;

endpackage

`default_nettype wire

// ==== src.f ====
+incdir+tests
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/exec_ctrl_if.sv
rtl/control_fsm.sv
rtl/register_file.sv
rtl/imm_gen.sv
rtl/exec_unit.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

// ==== tests/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int BODY_START = 69; // First word after prologue and directed block

logic [31:0] ref_regs [32];     // Model register file, x0 never written

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

// Byte offset, bit 0 dropped by the format
function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    logic [31:0] o;
    o = off;
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input int off, input logic [4:0] rd);
    logic [31:0] o;
    o = off;
    return {o[20], o[10:1], o[11], o[19:12], rd, OP_JAL};
endfunction

function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
endfunction

task automatic put_word(input int idx, input logic [31:0] word);
    imem[idx[7:0]] = word;
endtask

task automatic build_program();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          t;
    // Prologue gives every register a defined value
    for (int i = 1; i < 32; i++) begin
        r = $random(seed);
        put_word(2 * i - 2, enc_u(r[31:12], 5'(i), OP_LUI));
        put_word(2 * i - 1, enc_i(r[11:0], 5'(i), F3_ADD_SUB, 5'(i), OP_IMM));
    end
    put_word(62, enc_i(12'h055, 5'd0, F3_ADD_SUB, 5'd0, OP_IMM));  // Write to x0 dropped
    put_word(63, enc_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd7, OP_REG)); // x0 still zero
    put_word(64, enc_i(12'h000, 5'd1, 3'b010, 5'd8, 7'b0000011));  // LW, no-op here
    put_word(65, enc_j(8, 5'd1));                                     // Skips 66
    put_word(66, enc_i(12'h001, 5'd0, F3_ADD_SUB, 5'd9, OP_IMM));
    put_word(67, enc_i(12'(BODY_START * 4), 5'd0, 3'b000, 5'd2, OP_JALR)); // Skips 68
    put_word(68, enc_i(12'h002, 5'd0, F3_ADD_SUB, 5'd9, OP_IMM));
    for (int i = BODY_START; i < 255; i++) begin
        r   = $random(seed);
        f3  = r[14:12];
        rd  = r[11:7];
        rs1 = r[19:15];
        rs2 = r[24:20];
        case (rand_range(0, 15))
            0, 1, 2, 3: begin // Bit 30 only on ADD/SUB and SRL/SRA
                put_word(i, enc_r(((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && r[30]) ?
                                  7'h20 : 7'h00, rs2, rs1, f3, rd, OP_REG));
            end
            4, 5, 6, 7: begin
                imm = r[31:20];
                if (f3 == F3_SLL) imm[11:5] = 7'h00;
                if (f3 == F3_SRL_SRA) imm[11:5] = r[30] ? 7'h20 : 7'h00; // SRAI or SRLI
                put_word(i, enc_i(imm, rs1, f3, rd, OP_IMM));
            end
            8:  put_word(i, enc_u(r[31:12], rd, OP_LUI));
            9:  put_word(i, enc_u(r[31:12], rd, OP_AUIPC));
            10, 11, 12: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3  = F3_BEQ; // Illegal codes become a taken BEQ
                    rs2 = rs1;
                end
                t = rand_range(i + 1, 255);
                put_word(i, enc_b((t - i) * 4, rs2, rs1, f3));
            end
            13: begin
                t = rand_range(i + 1, 255);
                put_word(i, enc_j((t - i) * 4, rd));
            end
            14: begin
                t = rand_range(i + 1, 255);
                put_word(i, enc_i(12'(t * 4), 5'd0, 3'b000, rd, OP_JALR)); // Base x0
            end
            default: put_word(i, enc_i(r[31:20], rs1, 3'b010, rd, 7'b0000011)); // LW
        endcase
    end
    put_word(255, enc_j((BODY_START - 255) * 4, 5'd0)); // Loop back into the body
endtask

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// One instruction on the model state
function automatic void ref_step(input logic [31:0] pc, input logic [31:0] ins,
                                 output logic [31:0] npc, output logic we,
                                 output logic [4:0] rd, output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic        taken;
    rd    = ins[11:7];
    a     = ref_regs[ins[19:15]];
    b     = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    npc   = pc + 32'd4;
    we    = 1'b0;
    val   = '0;
    taken = 1'b0;
    case (ins[6:0])
        OP_REG: begin
            we  = 1'b1;
            val = alu_ref(ins[14:12], ins[30], a, b);
        end
        OP_IMM: begin
            we  = 1'b1;
            val = alu_ref(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, imm_i);
        end
        OP_LUI: begin
            we  = 1'b1;
            val = imm_u;
        end
        OP_AUIPC: begin
            we  = 1'b1;
            val = pc + imm_u;
        end
        OP_JAL: begin
            we  = 1'b1;
            val = pc + 32'd4;
            npc = pc + imm_j;
        end
        OP_JALR: begin
            we  = 1'b1;
            val = pc + 32'd4;
            npc = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            case (ins[14:12])
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                3'b111:  taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken) npc = pc + imm_b;
        end
        default: ; // Unsupported, pc + 4 and no write
    endcase
    if (rd == 5'd0) we = 1'b0; // x0 stays zero
    if (we) ref_regs[rd] = val;
endfunction

function automatic string instr_class(input logic [31:0] ins);
    case (ins[6:0])
        OP_REG:    return "alu_reg";
        OP_IMM:    return "alu_imm";
        OP_LUI:    return "lui";
        OP_AUIPC:  return "auipc";
        OP_JAL:    return "jal";
        OP_JALR:   return "jalr";
        OP_BRANCH: return "branch";
        default:   return "unsupported";
    endcase
endfunction

`endif

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, core_pkg::*; ();

    localparam int NUM_RETIRES         = 2000;
    localparam int RETIRE_TIMEOUT      = 8;
    localparam int FIRST_RETIRE_CYCLES = 3; // Falling edges from release into WRITEBACK
    localparam int RETIRE_PERIOD       = 4;

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;

    logic [31:0] imem [256]; // Word-indexed program
    integer      seed;

    `include "rv_ref_model.svh"

    rv_core u_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction fetch on the falling edge while the address is stable
    always @(negedge clk) begin
        imem_data <= imem[imem_addr[9:2]];
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
    endtask

    // Returns the number of falling edges waited
    task automatic wait_retire(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid && cycles < RETIRE_TIMEOUT);
        assert (retire_valid)
            else fail_run("Core stopped retiring: no retire_valid within 8 cycles");
    endtask

    initial begin
        int          cycles;
        int          expected_cycles;
        logic [31:0] exp_pc;
        logic [31:0] ins;
        logic [31:0] next_pc;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        string       cls;
        reset     = 1'b1;
        imem_data = '0;
        seed      = 32'hbed9;
        exp_pc    = RESET_PC;
        ref_regs  = '{default: '0};
        build_program();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < NUM_RETIRES; n++) begin
            wait_retire(cycles);
            expected_cycles = (n == 0) ? FIRST_RETIRE_CYCLES : RETIRE_PERIOD;
            assert (cycles == expected_cycles)
                else report_mismatch("retire spacing", 32'(expected_cycles), 32'(cycles));
            if (n == 0) begin
                assert (retire_pc == RESET_PC)
                    else report_mismatch("first retire_pc", RESET_PC, retire_pc);
            end
            ins = imem[exp_pc[9:2]];
            cls = instr_class(ins);
            ref_step(exp_pc, ins, next_pc, exp_we, exp_rd, exp_val);
            assert (retire_pc == exp_pc)
                else report_mismatch({cls, " retire_pc"}, exp_pc, retire_pc);
            // Fetch address still points at the retiring instruction
            assert (imem_addr == exp_pc)
                else report_mismatch({cls, " imem_addr"}, exp_pc, imem_addr);
            assert (rd_we == exp_we)
                else report_mismatch({cls, " rd_we"}, 32'(exp_we), 32'(rd_we));
            if (exp_we) begin // rd fields only mean something on a write
                assert (rd_addr == exp_rd)
                    else report_mismatch({cls, " rd_addr"}, 32'(exp_rd), 32'(rd_addr));
                assert (rd_data == exp_val)
                    else report_mismatch({cls, " rd_data"}, exp_val, rd_data);
            end
            exp_pc = next_pc;
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
